//--- Makefile
TOP := vmem_map_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vmem_map.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > run.log 2>&1 || true
	@cat run.log
	@if grep -q "Result: FAILED" run.log; then exit 1; fi
	@grep -q "Result: PASSED" run.log

lint:
	verilator --lint-only --timing --assert -f vmem_map.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

//--- design/map2_ram.sv
// second map level, one read and one write port on clk_a
// a colliding read returns the word from before the write
`timescale 1ns/1ns
`include "vmem_defs.svh"

module map2_ram
(
   input logic clk_a,
   input logic reset,
   input vmem_pkg::map2_addr_t raddr,
   input logic rden,
   output vmem_pkg::map2_entry_t q,
   input vmem_pkg::map2_addr_t waddr,
   input vmem_pkg::map2_entry_t wdata,
   input logic wren
);
   import vmem_pkg::*;

   map2_entry_t ram [0:(1 << `MAP2_AW)-1];

   // all entries start with access 00, so an unloaded page faults
   initial
   begin
      for (int i = 0; i < (1 << `MAP2_AW); i++)
      begin
         ram[i] = '0;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (wren)
      begin
         ram[waddr] <= wdata;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q <= '0;
      end
      else if (rden)
      begin
         q <= ram[raddr];
      end
   end

endmodule

//--- design/map_decode.sv
// one command per clock, taken whenever cmd_valid is high; nothing is ever refused
// fields of an unused group are don't-care, only the strobes are qualified
`timescale 1ns/1ns
`include "vmem_defs.svh"

module map_decode
(
   input logic clk_a,
   input logic reset,
   input logic cmd_valid,
   input vmem_pkg::cmd_op_t cmd_op,
   input vmem_pkg::vma_t cmd_vma,
   input vmem_pkg::map2_entry_t cmd_data,
   map_req_if.src req
);
   import vmem_pkg::*;

   logic is_lookup;
   logic is_load1;
   logic is_load2;

   always_comb
   begin
      is_lookup = cmd_valid && (cmd_op == OP_LOOKUP_RD || cmd_op == OP_LOOKUP_WR);
      is_load1 = cmd_valid && (cmd_op == OP_LOAD_MAP1);
      is_load2 = cmd_valid && (cmd_op == OP_LOAD_MAP2);
   end

   // strobes
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         req.lookup_valid <= 1'b0;
         req.map1_we <= 1'b0;
         req.map2_we <= 1'b0;
      end
      else
      begin
         req.lookup_valid <= is_lookup;
         req.map1_we <= is_load1;
         req.map2_we <= is_load2;
      end
   end

   // address split: map1 index 23:13, block low 12:8, offset 7:0
   always_ff @(posedge clk_a)
   begin
      req.lookup_is_wr <= (cmd_op == OP_LOOKUP_WR);
      req.map1_raddr <= cmd_vma[`VMA_WIDTH-1 -: `MAP1_AW];
      req.blk_low <= cmd_vma[`OFFSET_W +: `BLK_W];
      req.offset <= cmd_vma[`OFFSET_W-1:0];
   end

   // load payloads
   always_ff @(posedge clk_a)
   begin
      req.map1_waddr <= cmd_vma[`VMA_WIDTH-1 -: `MAP1_AW];
      req.map1_wdata <= cmd_data[`MAP1_DW-1:0];
      // map2 is loaded directly by its index in vma 9:0
      req.map2_waddr <= cmd_vma[`MAP2_AW-1:0];
      req.map2_wdata <= cmd_data;
   end

endmodule

//--- design/map_execute.sv
// two-stage walk through the maps, fixed two cycles from req to rsp
// loads write both levels one edge after decode, so a lookup sees only earlier loads
`timescale 1ns/1ns
`include "vmem_defs.svh"

module map_execute
(
   input logic clk_a,
   input logic reset,
   map_req_if.dst req,
   map_rsp_if.src rsp
);
   import vmem_pkg::*;

   map1_entry_t blk_num;

   logic s1_valid;
   logic s1_is_wr;
   logic [`BLK_W-1:0] s1_blk_low;
   offset_t s1_offset;

   part_2kx5dpram u_map1
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (req.map1_raddr),
      .rden_a    (req.lookup_valid),
      .q_a       (blk_num),
      .address_b (req.map1_waddr),
      .data_b    (req.map1_wdata),
      .wren_b    (req.map1_we)
   );

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         rsp.rsp_valid <= 1'b0;
      end
      else
      begin
         s1_valid <= req.lookup_valid;
         rsp.rsp_valid <= s1_valid;
      end
   end

   // lookup fields ride along with the RAM reads
   always_ff @(posedge clk_a)
   begin
      s1_is_wr <= req.lookup_is_wr;
      s1_blk_low <= req.blk_low;
      s1_offset <= req.offset;
      rsp.rsp_is_wr <= s1_is_wr;
      rsp.rsp_offset <= s1_offset;
   end

   // a load one cycle after a lookup writes on that lookup's map2 read edge, old data wins
   map2_ram u_map2
   (
      .clk_a (clk_a),
      .reset (reset),
      .raddr ({blk_num, s1_blk_low}),
      .rden  (s1_valid),
      .q     (rsp.rsp_entry),
      .waddr (req.map2_waddr),
      .wdata (req.map2_wdata),
      .wren  (req.map2_we)
   );

endmodule

//--- design/map_if.sv
// internal links of the map pipeline; plain levels, no back-pressure
`timescale 1ns/1ns
`include "vmem_defs.svh"

interface map_req_if;
   import vmem_pkg::*;

   logic lookup_valid;
   logic lookup_is_wr;
   map1_addr_t map1_raddr;
   offset_t offset;
   logic [`BLK_W-1:0] blk_low;

   logic map1_we;
   map1_addr_t map1_waddr;
   map1_entry_t map1_wdata;

   logic map2_we;
   map2_addr_t map2_waddr;
   map2_entry_t map2_wdata;

   modport src (output lookup_valid, lookup_is_wr, map1_raddr, offset, blk_low,
                output map1_we, map1_waddr, map1_wdata, map2_we, map2_waddr, map2_wdata);
   modport dst (input lookup_valid, lookup_is_wr, map1_raddr, offset, blk_low,
                input map1_we, map1_waddr, map1_wdata, map2_we, map2_waddr, map2_wdata);
endinterface

interface map_rsp_if;
   import vmem_pkg::*;

   logic rsp_valid;
   logic rsp_is_wr;
   map2_entry_t rsp_entry;
   offset_t rsp_offset;

   modport src (output rsp_valid, rsp_is_wr, rsp_entry, rsp_offset);
   modport dst (input rsp_valid, rsp_is_wr, rsp_entry, rsp_offset);
endinterface

//--- design/map_result.sv
// page from entry 13:0, access from 23:22; bits 21:14 of the entry are ignored
// res_paddr holds the last result between lookups
`timescale 1ns/1ns
`include "vmem_defs.svh"

module map_result
(
   input logic clk_a,
   input logic reset,
   map_rsp_if.dst rsp,
   output logic res_valid,
   output vmem_pkg::paddr_t res_paddr,
   output logic res_fault
);
   import vmem_pkg::*;

   ppage_t page;
   access_t acc;
   logic fault;

   always_comb
   begin
      page = rsp.rsp_entry[`PPAGE_W-1:0];
      acc = rsp.rsp_entry[`ACC_HI:`ACC_LO];
      // 0x never allowed, 10 is read-only
      fault = !acc[1] || (rsp.rsp_is_wr && !acc[0]);
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         res_valid <= 1'b0;
         res_fault <= 1'b0;
      end
      else
      begin
         res_valid <= rsp.rsp_valid;
         res_fault <= rsp.rsp_valid && fault;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         res_paddr <= '0;
      end
      else if (rsp.rsp_valid)
      begin
         res_paddr <= {page, rsp.rsp_offset};
      end
   end

endmodule

//--- design/part_2kx5dpram.sv
// first map level; port a reads, port b writes, both on clk_a
// read during write at the same address returns the old word
`timescale 1ns/1ns
`include "vmem_defs.svh"

module part_2kx5dpram
(
   input logic clk_a,
   input logic reset,
   input vmem_pkg::map1_addr_t address_a,
   input logic rden_a,
   output vmem_pkg::map1_entry_t q_a,
   input vmem_pkg::map1_addr_t address_b,
   input vmem_pkg::map1_entry_t data_b,
   input logic wren_b
);
   import vmem_pkg::*;

   map1_entry_t ram [0:(1 << `MAP1_AW)-1];

   // maps start out empty
   initial
   begin
      for (int i = 0; i < (1 << `MAP1_AW); i++)
      begin
         ram[i] = '0;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (wren_b)
      begin
         ram[address_b] <= data_b;
      end
   end

   // registered read, holds its word while rden_a is low
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         q_a <= ram[address_a];
      end
   end

endmodule

//--- design/vmem_defs.svh
// map geometry is fixed; the first level is 2k x 5 and the second level 1k x 24
// changing a width here also changes the field split of the virtual address
`ifndef VMEM_DEFS_SVH
`define VMEM_DEFS_SVH

`define VMA_WIDTH   24
`define MAP1_AW     11
`define MAP1_DW     5
`define MAP2_AW     10
`define MAP2_DW     24
`define PPAGE_W     14
`define OFFSET_W    8

// low half of the map2 index comes straight from the vma
`define BLK_W       (`MAP2_AW - `MAP1_DW)

// access bits in a map2 word
`define ACC_HI      23
`define ACC_LO      22

`endif

//--- design/vmem_map.sv
// two-level virtual map, lookup result three cycles after the command
// a lookup sees loads issued in earlier cycles only
`timescale 1ns/1ns

module vmem_map
(
   input logic clk_a,
   input logic reset,
   input logic cmd_valid,
   input vmem_pkg::cmd_op_t cmd_op,
   input vmem_pkg::vma_t cmd_vma,
   input vmem_pkg::map2_entry_t cmd_data,
   output logic res_valid,
   output vmem_pkg::paddr_t res_paddr,
   output logic res_fault
);

   map_req_if req_if ();
   map_rsp_if rsp_if ();

   map_decode u_decode
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_vma   (cmd_vma),
      .cmd_data  (cmd_data),
      .req       (req_if.src)
   );

   map_execute u_execute
   (
      .clk_a (clk_a),
      .reset (reset),
      .req   (req_if.dst),
      .rsp   (rsp_if.src)
   );

   map_result u_result
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .rsp       (rsp_if.dst),
      .res_valid (res_valid),
      .res_paddr (res_paddr),
      .res_fault (res_fault)
   );

endmodule

//--- design/vmem_pkg.sv
// types shared by the map pipeline; widths come from the defs header
// opcode values are fixed by the command encoding
`include "vmem_defs.svh"

package vmem_pkg;

   typedef logic [`VMA_WIDTH-1:0] vma_t;

   typedef logic [`MAP1_AW-1:0] map1_addr_t;
   typedef logic [`MAP1_DW-1:0] map1_entry_t;

   typedef logic [`MAP2_AW-1:0] map2_addr_t;
   typedef logic [`MAP2_DW-1:0] map2_entry_t;

   typedef logic [`PPAGE_W-1:0] ppage_t;
   typedef logic [`OFFSET_W-1:0] offset_t;
   typedef logic [`PPAGE_W+`OFFSET_W-1:0] paddr_t;

   // 11 read-write, 10 read-only, 0x no access
   typedef logic [`ACC_HI-`ACC_LO:0] access_t;

   typedef enum logic [1:0]
   {
      OP_LOOKUP_RD = 2'd0,
      OP_LOOKUP_WR = 2'd1,
      OP_LOAD_MAP1 = 2'd2,
      OP_LOAD_MAP2 = 2'd3
   } cmd_op_t;

endpackage

//--- tb/vmem_map_assertions.sv
// bound into vmem_map; assumes reset is only applied at the start of the run
// a result is registered three edges after its lookup and sampled on the fourth
`timescale 1ns/1ns

module vmem_map_assertions
(
   input logic clk_a,
   input logic reset,
   input logic cmd_valid,
   input vmem_pkg::cmd_op_t cmd_op,
   input logic res_valid,
   input vmem_pkg::paddr_t res_paddr,
   input logic res_fault
);
   import vmem_pkg::*;

   logic lookup_cmd;

   assign lookup_cmd = cmd_valid && !reset && (cmd_op == OP_LOOKUP_RD || cmd_op == OP_LOOKUP_WR);

   assert property (@(posedge clk_a) disable iff (reset) $past(lookup_cmd, 4) |-> res_valid)
   else $error("lookup gave no res_valid three cycles later");

   assert property (@(posedge clk_a) disable iff (reset) res_valid |-> $past(lookup_cmd, 4))
   else $error("res_valid high without a lookup three cycles earlier");

   // outputs are cleared on every reset edge
   assert property (@(posedge clk_a) reset |=> (!res_valid && !res_fault && res_paddr == '0))
   else $error("outputs not low during reset");

endmodule

bind vmem_map vmem_map_assertions u_assertions
(
   .clk_a     (clk_a),
   .reset     (reset),
   .cmd_valid (cmd_valid),
   .cmd_op    (cmd_op),
   .res_valid (res_valid),
   .res_paddr (res_paddr),
   .res_fault (res_fault)
);

//--- tb/vmem_map_tb.sv
// random mix of loads and lookups checked against a model of both map levels
// lookups use map1 entries 0..7 and block low 0..3 so loads and lookups collide often
`timescale 1ns/1ns

module vmem_map_tb;
   import vmem_pkg::*;

   localparam int NUM_DIRECTED = 24;
   localparam int NUM_B2B = 16;
   localparam int NUM_RANDOM = 400;
   // one command per 8 ns cycle, plus reset and drain slack
   localparam int WATCHDOG_NS = (NUM_DIRECTED + NUM_B2B + NUM_RANDOM + 8 + 200) * 8;

   logic clk_a;
   logic reset;
   logic cmd_valid;
   cmd_op_t cmd_op;
   vma_t cmd_vma;
   map2_entry_t cmd_data;
   logic res_valid;
   paddr_t res_paddr;
   logic res_fault;

   integer seed;
   int edge_cnt;
   int checks;
   int errors;
   int test_checks;
   int test_errors;

   logic [4:0] map1_m [0:2047];
   logic [23:0] map2_m [0:1023];
   paddr_t paddr_q [$];
   logic fault_q [$];
   int due_q [$];

   vmem_map dut
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_vma   (cmd_vma),
      .cmd_data  (cmd_data),
      .res_valid (res_valid),
      .res_paddr (res_paddr),
      .res_fault (res_fault)
   );

   always #4 clk_a = ~clk_a;

   always @(posedge clk_a)
   begin
      edge_cnt <= edge_cnt + 1;
   end

   task automatic issue(input cmd_op_t op, input vma_t vma, input map2_entry_t data);
      @(posedge clk_a);
      #1;
      cmd_valid = 1'b1;
      cmd_op = op;
      cmd_vma = vma;
      cmd_data = data;
   endtask

   task automatic idle();
      @(posedge clk_a);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic load_map1(input logic [10:0] idx, input logic [4:0] blk);
      issue(OP_LOAD_MAP1, {idx, 13'd0}, {19'd0, blk});
   endtask

   task automatic load_map2(input logic [4:0] blk, input logic [4:0] low,
                            input logic [1:0] acc, input logic [13:0] page);
      issue(OP_LOAD_MAP2, {14'd0, blk, low}, {acc, 8'h00, page});
   endtask

   task automatic lookup(input logic wr, input logic [10:0] idx, input logic [4:0] low,
                         input logic [7:0] off);
      issue(wr ? OP_LOOKUP_WR : OP_LOOKUP_RD, {idx, low, off}, 24'd0);
   endtask

   function automatic vma_t lookup_vma();
      logic [31:0] r;
      r = $random(seed);
      return {8'd0, r[2:0], 3'd0, r[4:3], r[15:8]};
   endfunction

   // map2 index {block, low} lands in the range the lookups reach
   function automatic vma_t map2_vma();
      logic [31:0] r;
      r = $random(seed);
      return {r[23:10], 2'b00, r[2:0], 3'b000, r[4:3]};
   endfunction

   function automatic map2_entry_t map1_data();
      logic [31:0] r;
      r = $random(seed);
      return {r[23:5], 2'b00, r[2:0]};
   endfunction

   // one command per cycle, so applying commands in issue order gives the ordering rule
   task automatic model_step(input cmd_op_t op, input vma_t vma, input map2_entry_t data);
      logic [4:0] blk;
      logic [23:0] entry;
      logic wr;
      logic exp_fault;
      case (op)
         OP_LOAD_MAP1:
         begin
            map1_m[vma[23:13]] = data[4:0];
         end
         OP_LOAD_MAP2:
         begin
            map2_m[vma[9:0]] = data;
         end
         default:
         begin
            wr = (op == OP_LOOKUP_WR);
            blk = map1_m[vma[23:13]];
            entry = map2_m[{blk, vma[12:8]}];
            paddr_q.push_back({entry[13:0], vma[7:0]});
            // access table: read-write, read-only, no access
            case (entry[23:22])
               2'b11: exp_fault = 1'b0;
               2'b10: exp_fault = wr;
               default: exp_fault = 1'b1;
            endcase
            fault_q.push_back(exp_fault);
            // sampled on the next edge, registered three edges after that
            due_q.push_back(edge_cnt + 4);
         end
      endcase
   endtask

   task automatic check_result();
      paddr_t exp_paddr;
      logic exp_fault;
      if (due_q.size() > 0 && due_q[0] == edge_cnt)
      begin
         exp_paddr = paddr_q.pop_front();
         exp_fault = fault_q.pop_front();
         due_q.delete(0);
         checks++;
         assert (res_valid)
         else
         begin
            $display("res_valid missing at edge %0d where a lookup result was due", edge_cnt);
            errors++;
         end
         assert (res_paddr == exp_paddr)
         else
         begin
            $display("[FAIL] res_paddr expected %h actual %h", exp_paddr, res_paddr);
            errors++;
         end
         assert (res_fault == exp_fault)
         else
         begin
            $display("[FAIL] res_fault expected %h actual %h", exp_fault, res_fault);
            errors++;
         end
      end
      else
      begin
         assert (!res_valid)
         else
         begin
            $display("res_valid high at edge %0d with no lookup result due", edge_cnt);
            errors++;
         end
      end
   endtask

   // inputs are stable mid-cycle, so results and new commands are both taken here
   always @(negedge clk_a)
   begin
      if (reset)
      begin
         if (edge_cnt > 0)
         begin
            checks++;
            assert (!res_valid && !res_fault && res_paddr == '0)
            else
            begin
               $display("outputs not cleared during reset");
               errors++;
            end
         end
      end
      else
      begin
         check_result();
         if (cmd_valid)
         begin
            model_step(cmd_op, cmd_vma, cmd_data);
         end
      end
   end

   task automatic end_test(input string name);
      idle();
      while (due_q.size() > 0)
      begin
         @(posedge clk_a);
      end
      repeat (2) @(posedge clk_a);
      $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns with %0d lookups pending", WATCHDOG_NS,
               due_q.size());
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      seed = 32'h58f4662c;
      clk_a = 1'b0;
      reset = 1'b1;
      cmd_valid = 1'b0;
      cmd_op = OP_LOOKUP_RD;
      cmd_vma = '0;
      cmd_data = '0;
      edge_cnt = 0;
      checks = 0;
      errors = 0;
      test_checks = 0;
      test_errors = 0;
      for (int i = 0; i < 2048; i++)
      begin
         map1_m[i] = '0;
      end
      for (int i = 0; i < 1024; i++)
      begin
         map2_m[i] = '0;
      end
      repeat (8) @(posedge clk_a);
      #1;
      reset = 1'b0;

      @(negedge clk_a);
      checks++;
      assert (!res_fault && res_paddr == '0)
      else
      begin
         $display("outputs not zero just after reset");
         errors++;
      end
      lookup(1'b0, 11'd3, 5'd7, 8'h42);
      end_test("reset and empty maps");

      load_map1(11'd5, 5'd9);
      load_map1(11'd6, 5'h1f);
      load_map2(5'd9, 5'd1, 2'b11, 14'h2a5c);
      load_map2(5'd9, 5'd2, 2'b10, 14'h1234);
      load_map2(5'd9, 5'd3, 2'b00, 14'h0777);
      load_map2(5'd9, 5'd4, 2'b01, 14'h3fff);
      load_map2(5'h1f, 5'd0, 2'b11, 14'h0001);
      lookup(1'b0, 11'd5, 5'd1, 8'h10);
      lookup(1'b0, 11'd5, 5'd2, 8'h5a);
      lookup(1'b0, 11'd6, 5'd0, 8'hff);
      end_test("directed read lookups");

      lookup(1'b1, 11'd5, 5'd1, 8'h01);
      lookup(1'b1, 11'd5, 5'd2, 8'h02);
      lookup(1'b1, 11'd5, 5'd3, 8'h03);
      lookup(1'b1, 11'd5, 5'd4, 8'h04);
      lookup(1'b0, 11'd5, 5'd3, 8'h05);
      lookup(1'b0, 11'd5, 5'd4, 8'h06);
      end_test("access rights");

      for (int i = 0; i < NUM_B2B; i++)
      begin
         lookup(i[0], 11'd5, {2'b00, i[2:0]}, 8'(i * 17));
      end
      end_test("back-to-back lookups");

      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         r = $random(seed);
         if (r[5:3] == 3'd0)
         begin
            idle();
         end
         else
         begin
            case (r[1:0])
               2'd0: issue(OP_LOOKUP_RD, lookup_vma(), '0);
               2'd1: issue(OP_LOOKUP_WR, lookup_vma(), '0);
               2'd2: issue(OP_LOAD_MAP1, lookup_vma(), map1_data());
               default: issue(OP_LOAD_MAP2, map2_vma(), map2_entry_t'($random(seed)));
            endcase
         end
      end
      end_test("random loads and lookups");

      $display("all tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- vmem_map.f
+incdir+design
design/vmem_pkg.sv
design/map_if.sv
design/map_decode.sv
design/part_2kx5dpram.sv
design/map2_ram.sv
design/map_execute.sv
design/map_result.sv
design/vmem_map.sv
tb/vmem_map_assertions.sv
tb/vmem_map_tb.sv
